/* hw/snooper_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Control-flow trace snooper package
// Shared widths, trace record and buffer entry layouts, the control
// register word and the register map of the configuration port
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package snooper_pkg;

   localparam int unsigned PcWidth      = 32;
   localparam int unsigned RegAddrWidth = 3;
   localparam int unsigned RegDataWidth = 32;

   // RISC-V privilege levels
   typedef enum logic [1:0] {
      PRIV_U    = 2'd0,
      PRIV_S    = 2'd1,
      PRIV_RSVD = 2'd2,
      PRIV_M    = 2'd3
   } priv_lvl_e;

   // Control-transfer types, also the bit index into type_mask
   typedef enum logic [2:0] {
      CTR_BR_TAKEN  = 3'd0,
      CTR_BR_NTAKEN = 3'd1,
      CTR_JUMP      = 3'd2,
      CTR_CALL      = 3'd3,
      CTR_RET       = 3'd4,
      CTR_EXC       = 3'd5,
      CTR_IRQ       = 3'd6,
      CTR_ERET      = 3'd7
   } ctr_type_e;

   // Retired control-flow record from the core
   typedef struct packed {
      logic                 valid;
      priv_lvl_e            priv;
      ctr_type_e            ctr_type;
      logic [PcWidth-1:0]   pc_src;
      logic [PcWidth-1:0]   pc_dst;
   } trace_t;

   // Stored record, trigger marks the entry that froze the buffer
   typedef struct packed {
      logic                 trigger;
      priv_lvl_e            priv;
      ctr_type_e            ctr_type;
      logic [PcWidth-1:0]   pc_src;
      logic [PcWidth-1:0]   pc_dst;
   } entry_t;

   localparam int unsigned EntryWidth = $bits(entry_t);

   // Control register, listed from bit 31 down to bit 0
   typedef struct packed {
      logic [15:0] spare;
      logic [7:0]  type_mask;
      logic [3:0]  priv_mask;
      logic        rearm;
      logic        core_select;
      logic        trig_en;
      logic        enable;
   } ctrl_fields_t;

   typedef union packed {
      logic [RegDataWidth-1:0] raw;
      ctrl_fields_t            fields;
   } ctrl_word_u;

   // Register map
   localparam logic [RegAddrWidth-1:0] ADDR_CTRL     = 3'd0;
   localparam logic [RegAddrWidth-1:0] ADDR_RANGE_LO = 3'd1;
   localparam logic [RegAddrWidth-1:0] ADDR_RANGE_HI = 3'd2;
   localparam logic [RegAddrWidth-1:0] ADDR_TRIG_PC  = 3'd3;
   localparam logic [RegAddrWidth-1:0] ADDR_STATUS   = 3'd4;

endpackage

`default_nettype wire

/* hw/snoop_cfg_if.sv */
////////////////////////////////////////////////////////////////////////////
// Snooper configuration interface
// Carries the programmed fields from the register block to the
// filter, trigger and recorder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface snoop_cfg_if
   import snooper_pkg::*;
();

   logic               enable;
   logic               trig_en;
   logic               rearm;
   logic [3:0]         priv_mask;
   logic [7:0]         type_mask;
   logic [PcWidth-1:0] range_lo;
   logic [PcWidth-1:0] range_hi;
   logic [PcWidth-1:0] trig_pc;

   modport regs (
      output enable, trig_en, rearm, priv_mask, type_mask,
      output range_lo, range_hi, trig_pc
   );

   modport filter (
      input enable, priv_mask, type_mask, range_lo, range_hi
   );

   modport trigger (input trig_en, trig_pc);

   modport recorder (input rearm);

endinterface

`default_nettype wire

/* hw/snoop_cfg_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Snooper register block
// Control, PC window and trigger target registers behind a strobe port,
// re-arm pulse generation and status readback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module snoop_cfg_regs
   import snooper_pkg::*;
#(
   parameter int unsigned BufDepth = 16
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic                          cfg_we_i,
   input  logic [RegAddrWidth-1:0]       cfg_addr_i,
   input  logic [RegDataWidth-1:0]       cfg_wdata_i,
   output logic [RegDataWidth-1:0]       cfg_rdata_o,
   input  logic [$clog2(BufDepth)-1:0]   first_idx_i,
   input  logic [$clog2(BufDepth)-1:0]   last_idx_i,
   input  logic [$clog2(BufDepth+1)-1:0] count_i,
   input  logic                          frozen_i,
   output logic                          core_select_o,
   snoop_cfg_if.regs                     cfg
);

   ctrl_word_u         wdata_u;
   ctrl_word_u         ctrl_rd_u;
   ctrl_fields_t       ctrl_wr;
   ctrl_fields_t       ctrl_q;
   logic               rearm_q;
   logic [PcWidth-1:0] range_lo_q;
   logic [PcWidth-1:0] range_hi_q;
   logic [PcWidth-1:0] trig_pc_q;
   logic [31:0]        status;

   ////////////////////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////////////////////

   assign wdata_u.raw = cfg_wdata_i;

   // rearm is a command, spare bits are hardwired to zero
   always_comb begin
      ctrl_wr       = wdata_u.fields;
      ctrl_wr.rearm = 1'b0;
      ctrl_wr.spare = '0;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q     <= '0;
         rearm_q    <= 1'b0;
         range_lo_q <= '0;
         range_hi_q <= '0;
         trig_pc_q  <= '0;
      end else begin
         rearm_q <= cfg_we_i && (cfg_addr_i == ADDR_CTRL) && wdata_u.fields.rearm;
         if (cfg_we_i) begin
            case (cfg_addr_i)
               ADDR_CTRL:     ctrl_q     <= ctrl_wr;
               ADDR_RANGE_LO: range_lo_q <= cfg_wdata_i;
               ADDR_RANGE_HI: range_hi_q <= cfg_wdata_i;
               ADDR_TRIG_PC:  trig_pc_q  <= cfg_wdata_i;
               default: ;
            endcase
         end
      end
   end

   // Field decode towards the datapath
   assign cfg.enable     = ctrl_q.enable;
   assign cfg.trig_en    = ctrl_q.trig_en;
   assign cfg.priv_mask  = ctrl_q.priv_mask;
   assign cfg.type_mask  = ctrl_q.type_mask;
   assign cfg.rearm      = rearm_q;
   assign cfg.range_lo   = range_lo_q;
   assign cfg.range_hi   = range_hi_q;
   assign cfg.trig_pc    = trig_pc_q;
   assign core_select_o  = ctrl_q.core_select;

   ////////////////////////////////////////////////////////////////////////////
   // Readback
   ////////////////////////////////////////////////////////////////////////////

   assign ctrl_rd_u.fields = ctrl_q;

   // frozen | 7 zero bits | count | first | last
   assign status = {frozen_i, 7'd0, 8'(count_i), 8'(first_idx_i), 8'(last_idx_i)};

   always_comb begin
      case (cfg_addr_i)
         ADDR_CTRL:     cfg_rdata_o = ctrl_rd_u.raw;
         ADDR_RANGE_LO: cfg_rdata_o = range_lo_q;
         ADDR_RANGE_HI: cfg_rdata_o = range_hi_q;
         ADDR_TRIG_PC:  cfg_rdata_o = trig_pc_q;
         ADDR_STATUS:   cfg_rdata_o = status;
         default:       cfg_rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/trace_filter.sv */
////////////////////////////////////////////////////////////////////////////
// Trace filter
// Registers the keep decision for each record from the source-PC window,
// privilege mask and transfer-type mask
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trace_filter
   import snooper_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  trace_t      trace_i,
   snoop_cfg_if.filter cfg,
   output logic        keep_o,
   output entry_t      entry_o
);

   logic in_window;
   logic priv_ok;
   logic type_ok;
   logic keep_d;

   // Inclusive window on the source PC
   assign in_window = (trace_i.pc_src >= cfg.range_lo) && (trace_i.pc_src <= cfg.range_hi);
   assign priv_ok   = cfg.priv_mask[trace_i.priv];
   assign type_ok   = cfg.type_mask[trace_i.ctr_type];

   assign keep_d = trace_i.valid && cfg.enable && in_window && priv_ok && type_ok;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         keep_o <= 1'b0;
      end else begin
         keep_o <= keep_d;
      end
   end

   // Payload follows keep_o, trigger flag is added by the recorder
   always_ff @(posedge clk_i) begin
      entry_o.trigger  <= 1'b0;
      entry_o.priv     <= trace_i.priv;
      entry_o.ctr_type <= trace_i.ctr_type;
      entry_o.pc_src   <= trace_i.pc_src;
      entry_o.pc_dst   <= trace_i.pc_dst;
   end

endmodule

`default_nettype wire

/* hw/trace_trigger.sv */
////////////////////////////////////////////////////////////////////////////
// Trace trigger
// Flags a record whose destination PC equals the programmed target,
// independent of the filter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trace_trigger
   import snooper_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  trace_t       trace_i,
   snoop_cfg_if.trigger cfg,
   output logic         hit_o
);

   logic pc_match;
   logic hit_d;

   assign pc_match = (trace_i.pc_dst == cfg.trig_pc);
   assign hit_d    = trace_i.valid && cfg.trig_en && pc_match;

   // One register stage, aligned with keep from the filter.
   // A match on consecutive records gives consecutive pulses.
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hit_o <= 1'b0;
      end else begin
         hit_o <= hit_d;
      end
   end

endmodule

`default_nettype wire

/* hw/trace_recorder.sv */
////////////////////////////////////////////////////////////////////////////
// Trace recorder
// Circular buffer of kept records with first/last/count tracking,
// freeze on trigger and a registered software read port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trace_recorder
   import snooper_pkg::*;
#(
   parameter int unsigned BufDepth = 16
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic                          keep_i,
   input  logic                          hit_i,
   input  entry_t                        entry_i,
   snoop_cfg_if.recorder                 cfg,
   input  logic [$clog2(BufDepth)-1:0]   rd_addr_i,
   output entry_t                        rd_data_o,
   output logic [$clog2(BufDepth)-1:0]   first_idx_o,
   output logic [$clog2(BufDepth)-1:0]   last_idx_o,
   output logic [$clog2(BufDepth+1)-1:0] count_o,
   output logic                          frozen_o
);

   localparam int unsigned IdxW = $clog2(BufDepth);
   localparam int unsigned CntW = $clog2(BufDepth + 1);

   entry_t            mem [BufDepth];
   entry_t            wr_entry;
   logic              wr_en;
   logic [IdxW-1:0]   wr_ptr_q;
   logic [IdxW-1:0]   last_q;
   logic [CntW-1:0]   count_q;
   logic              frozen_q;
   logic              full;

   ////////////////////////////////////////////////////////////////////////////
   // Write path
   ////////////////////////////////////////////////////////////////////////////

   // Frozen is sampled before the hit that sets it, so the
   // triggering record itself still gets stored
   assign wr_en = keep_i && !frozen_q;
   assign full  = (count_q == CntW'(BufDepth));

   always_comb begin
      wr_entry         = entry_i;
      wr_entry.trigger = entry_i.trigger | hit_i;
   end

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= wr_entry;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         last_q   <= '0;
         count_q  <= '0;
      end else if (wr_en) begin
         // Depth is a power of two, so the pointer wraps by itself
         wr_ptr_q <= wr_ptr_q + 1'b1;
         last_q   <= wr_ptr_q;
         if (!full) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Freeze control
   ////////////////////////////////////////////////////////////////////////////

   // A hit wins over a re-arm arriving at the same edge
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         frozen_q <= 1'b0;
      end else if (hit_i) begin
         frozen_q <= 1'b1;
      end else if (cfg.rearm) begin
         frozen_q <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Status and read port
   ////////////////////////////////////////////////////////////////////////////

   // Oldest entry sits count places behind the write pointer.
   // When full the truncated count is zero and first equals wr_ptr.
   assign first_idx_o = wr_ptr_q - IdxW'(count_q);
   assign last_idx_o  = last_q;
   assign count_o     = count_q;
   assign frozen_o    = frozen_q;

   always_ff @(posedge clk_i) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

`default_nettype wire

/* hw/snooper_top.sv */
////////////////////////////////////////////////////////////////////////////
// Control-flow trace snooper top level
// Filter and trigger side by side feeding the recorder, programmed
// through the register block
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module snooper_top
   import snooper_pkg::*;
#(
   parameter int unsigned BufDepth = 16
) (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   // Trace from the core
   input  logic                        trace_valid_i,
   input  logic [1:0]                  trace_priv_i,
   input  logic [2:0]                  trace_type_i,
   input  logic [PcWidth-1:0]          trace_pc_src_i,
   input  logic [PcWidth-1:0]          trace_pc_dst_i,
   // Register port
   input  logic                        cfg_we_i,
   input  logic [RegAddrWidth-1:0]     cfg_addr_i,
   input  logic [RegDataWidth-1:0]     cfg_wdata_i,
   output logic [RegDataWidth-1:0]     cfg_rdata_o,
   // Buffer read port
   input  logic [$clog2(BufDepth)-1:0] rd_addr_i,
   output logic [EntryWidth-1:0]       rd_data_o,
   output logic                        trigger_o,
   output logic                        core_select_o
);

   localparam int unsigned IdxW = $clog2(BufDepth);
   localparam int unsigned CntW = $clog2(BufDepth + 1);

   trace_t          trace;
   entry_t          filt_entry;
   entry_t          rd_entry;
   logic            keep;
   logic            hit;
   logic [IdxW-1:0] first_idx;
   logic [IdxW-1:0] last_idx;
   logic [CntW-1:0] count;
   logic            frozen;

   snoop_cfg_if cfg_if ();

   assign trace.valid    = trace_valid_i;
   assign trace.priv     = priv_lvl_e'(trace_priv_i);
   assign trace.ctr_type = ctr_type_e'(trace_type_i);
   assign trace.pc_src   = trace_pc_src_i;
   assign trace.pc_dst   = trace_pc_dst_i;

   assign rd_data_o = rd_entry;
   assign trigger_o = hit;

   ////////////////////////////////////////////////////////////////////////////
   // Configuration
   ////////////////////////////////////////////////////////////////////////////

   snoop_cfg_regs #(
      .BufDepth      ( BufDepth      )
   ) i_cfg_regs (
      .clk_i         ( clk_i         ),
      .rst_n_i       ( rst_n_i       ),
      .cfg_we_i      ( cfg_we_i      ),
      .cfg_addr_i    ( cfg_addr_i    ),
      .cfg_wdata_i   ( cfg_wdata_i   ),
      .cfg_rdata_o   ( cfg_rdata_o   ),
      .first_idx_i   ( first_idx     ),
      .last_idx_i    ( last_idx      ),
      .count_i       ( count         ),
      .frozen_i      ( frozen        ),
      .core_select_o ( core_select_o ),
      .cfg           ( cfg_if.regs   )
   );

   ////////////////////////////////////////////////////////////////////////////
   // Snooping datapath
   ////////////////////////////////////////////////////////////////////////////

   trace_filter i_trace_filter (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .trace_i ( trace         ),
      .cfg     ( cfg_if.filter ),
      .keep_o  ( keep          ),
      .entry_o ( filt_entry    )
   );

   trace_trigger i_trace_trigger (
      .clk_i   ( clk_i          ),
      .rst_n_i ( rst_n_i        ),
      .trace_i ( trace          ),
      .cfg     ( cfg_if.trigger ),
      .hit_o   ( hit            )
   );

   trace_recorder #(
      .BufDepth    ( BufDepth        )
   ) i_trace_recorder (
      .clk_i       ( clk_i           ),
      .rst_n_i     ( rst_n_i         ),
      .keep_i      ( keep            ),
      .hit_i       ( hit             ),
      .entry_i     ( filt_entry      ),
      .cfg         ( cfg_if.recorder ),
      .rd_addr_i   ( rd_addr_i       ),
      .rd_data_o   ( rd_entry        ),
      .first_idx_o ( first_idx       ),
      .last_idx_o  ( last_idx        ),
      .count_o     ( count           ),
      .frozen_o    ( frozen          )
   );

endmodule

`default_nettype wire

/* testbench/tb_snooper.sv */
////////////////////////////////////////////////////////////////////////////
// Trace snooper testbench
// Runs a table of register writes, traces and reads through the snooper
// and compares every response with a reference model of the buffer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_snooper
   import snooper_pkg::*;
();

   localparam int unsigned BufDepth = 16;
   localparam int unsigned IdxW     = $clog2(BufDepth);
   localparam int unsigned NumRows  = 45;

   // Row kinds
   localparam logic [1:0] K_WR = 2'd0;
   localparam logic [1:0] K_TR = 2'd1;
   localparam logic [1:0] K_RB = 2'd2;
   localparam logic [1:0] K_RR = 2'd3;

   typedef struct packed {
      logic [1:0]  kind;
      logic [7:0]  arg;    // register address, buffer index or trace count
      logic [31:0] data;   // write data, first pc_src or expected readback
      logic [1:0]  priv;
      logic [2:0]  ctype;
      logic        trig;   // pc_dst is the trigger target
      logic        model;  // expected value or index taken from the model
   } row_t;

   localparam row_t Rows [NumRows] = '{
      '{K_RR, 8'd4,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},  // status after reset
      '{K_RR, 8'd0,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_TR, 8'd2,  32'h0000_1000, 2'd3, 3'd3, 1'b0, 1'b0},  // snooper still disabled
      '{K_RR, 8'd4,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      '{K_WR, 8'd1,  32'h0000_1000, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_WR, 8'd2,  32'h0000_1FFF, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_WR, 8'd3,  32'h8000_0040, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RR, 8'd1,  32'h0000_1000, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RR, 8'd2,  32'h0000_1FFF, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RR, 8'd3,  32'h8000_0040, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RR, 8'd7,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b0},  // unmapped address
      // Enable, core select, U and M, jump/call/return
      '{K_WR, 8'd0,  32'h0000_1C95, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_TR, 8'd1,  32'h0000_1000, 2'd3, 3'd3, 1'b0, 1'b0},
      '{K_TR, 8'd1,  32'h0000_0FFC, 2'd3, 3'd3, 1'b0, 1'b0},
      '{K_TR, 8'd1,  32'h0000_2000, 2'd3, 3'd4, 1'b0, 1'b0},
      '{K_TR, 8'd1,  32'h0000_1100, 2'd1, 3'd3, 1'b0, 1'b0},
      '{K_TR, 8'd1,  32'h0000_1104, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_TR, 8'd1,  32'h0000_1FFF, 2'd0, 3'd4, 1'b0, 1'b0},
      '{K_RR, 8'd4,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      '{K_RB, 8'd0,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RB, 8'd1,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b0},
      // Enough kept records to wrap the ring
      '{K_TR, 8'd17, 32'h0000_1200, 2'd3, 3'd2, 1'b0, 1'b0},
      '{K_RR, 8'd4,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      '{K_RB, 8'd0,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RB, 8'd2,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RB, 8'd15, 32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RB, 8'd0,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      // Trigger on a record the filter drops
      '{K_WR, 8'd0,  32'h0000_1C97, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_TR, 8'd1,  32'h0000_1300, 2'd1, 3'd3, 1'b1, 1'b0},
      '{K_RR, 8'd4,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      '{K_TR, 8'd3,  32'h0000_1400, 2'd3, 3'd3, 1'b0, 1'b0},
      '{K_RR, 8'd4,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      '{K_RB, 8'd0,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      // Re-arm with the spare bits set
      '{K_WR, 8'd0,  32'hFFFF_1C9F, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RR, 8'd0,  32'h0000_1C97, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RR, 8'd4,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      '{K_TR, 8'd2,  32'h0000_1500, 2'd0, 3'd4, 1'b0, 1'b0},
      '{K_TR, 8'd1,  32'h0000_1600, 2'd3, 3'd3, 1'b1, 1'b0},  // kept trigger record
      '{K_TR, 8'd1,  32'h0000_1604, 2'd3, 3'd3, 1'b0, 1'b0},
      '{K_RR, 8'd4,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      '{K_RB, 8'd0,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b1},
      '{K_RB, 8'd3,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RB, 8'd4,  32'h0000_0000, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_WR, 8'd0,  32'h0000_1C91, 2'd0, 3'd0, 1'b0, 1'b0},
      '{K_RR, 8'd0,  32'h0000_1C91, 2'd0, 3'd0, 1'b0, 1'b0}
   };

   logic                  clk_i;
   logic                  rst_n_i;
   logic                  trace_valid_i;
   logic [1:0]            trace_priv_i;
   logic [2:0]            trace_type_i;
   logic [31:0]           trace_pc_src_i;
   logic [31:0]           trace_pc_dst_i;
   logic                  cfg_we_i;
   logic [2:0]            cfg_addr_i;
   logic [31:0]           cfg_wdata_i;
   logic [31:0]           cfg_rdata_o;
   logic [IdxW-1:0]       rd_addr_i;
   logic [EntryWidth-1:0] rd_data_o;
   logic                  trigger_o;
   logic                  core_select_o;

   // Reference model state
   logic [31:0]           m_ctrl;
   logic [31:0]           m_lo;
   logic [31:0]           m_hi;
   logic [31:0]           m_trig;
   logic [EntryWidth-1:0] m_mem [BufDepth];
   logic [IdxW-1:0]       m_wr;
   logic [IdxW-1:0]       m_last;
   logic [IdxW-1:0]       m_first;
   int unsigned           m_count;
   logic                  m_frozen;
   logic [31:0]           lfsr_q;

   snooper_top #(
      .BufDepth       ( BufDepth       )
   ) snooper_top_i (
      .clk_i          ( clk_i          ),
      .rst_n_i        ( rst_n_i        ),
      .trace_valid_i  ( trace_valid_i  ),
      .trace_priv_i   ( trace_priv_i   ),
      .trace_type_i   ( trace_type_i   ),
      .trace_pc_src_i ( trace_pc_src_i ),
      .trace_pc_dst_i ( trace_pc_dst_i ),
      .cfg_we_i       ( cfg_we_i       ),
      .cfg_addr_i     ( cfg_addr_i     ),
      .cfg_wdata_i    ( cfg_wdata_i    ),
      .cfg_rdata_o    ( cfg_rdata_o    ),
      .rd_addr_i      ( rd_addr_i      ),
      .rd_data_o      ( rd_data_o      ),
      .trigger_o      ( trigger_o      ),
      .core_select_o  ( core_select_o  )
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Error handling and random numbers
   ////////////////////////////////////////////////////////////////////////////

   task automatic stop_run();
      $display("Checks failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [EntryWidth-1:0] exp,
                              input logic [EntryWidth-1:0] act);
      assert (act === exp)
      else begin
         $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
         stop_run();
      end
   endtask

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_pc(output logic [31:0] pc);
      pc = m_trig;
      while (pc == m_trig) begin
         for (int b = 0; b < 32; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            pc[b]  = lfsr_q[0];
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   task automatic model_write(input logic [2:0] addr, input logic [31:0] data);
      case (addr)
         ADDR_CTRL: begin
            // rearm and the spare bits are never stored
            m_ctrl = data & 32'h0000_FFF7;
            if (data[3]) begin
               m_frozen = 1'b0;
            end
         end
         ADDR_RANGE_LO: m_lo = data;
         ADDR_RANGE_HI: m_hi = data;
         ADDR_TRIG_PC:  m_trig = data;
         default: ;
      endcase
   endtask

   task automatic model_trace(input logic [1:0] priv, input logic [2:0] ctype,
                              input logic [31:0] src, input logic [31:0] dst,
                              output logic hit);
      logic [3:0] pmask;
      logic [7:0] tmask;
      logic       keep;
      pmask = m_ctrl[7:4];
      tmask = m_ctrl[15:8];
      keep  = m_ctrl[0] && (src >= m_lo) && (src <= m_hi) && pmask[priv] && tmask[ctype];
      hit   = m_ctrl[1] && (dst == m_trig);
      if (keep && !m_frozen) begin
         m_mem[m_wr] = {hit, priv, ctype, src, dst};
         m_last      = m_wr;
         m_wr        = m_wr + IdxW'(1);
         // A full ring overwrites its oldest entry
         if (m_count < BufDepth) begin
            m_count = m_count + 1;
         end else begin
            m_first = m_first + IdxW'(1);
         end
      end
      if (hit) begin
         m_frozen = 1'b1;
      end
   endtask

   function automatic logic [31:0] model_status();
      model_status = {m_frozen, 7'd0, 8'(m_count), 8'(m_first), 8'(m_last)};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Row sequencing
   ////////////////////////////////////////////////////////////////////////////

   // Every row starts and ends 1 ns after a rising edge
   task automatic apply_row(input row_t r);
      logic [31:0]     src;
      logic [31:0]     dst;
      logic [31:0]     exp_word;
      logic            exp_hit;
      logic [IdxW-1:0] idx;
      case (r.kind)
         K_WR: begin
            cfg_we_i    = 1'b1;
            cfg_addr_i  = r.arg[2:0];
            cfg_wdata_i = r.data;
            @(posedge clk_i);
            #1;
            cfg_we_i = 1'b0;
            model_write(r.arg[2:0], r.data);
            @(posedge clk_i);
            #1;
         end
         K_TR: begin
            for (int j = 0; j < r.arg; j++) begin
               src = r.data + 32'(4 * j);
               if (r.trig) begin
                  dst = m_trig;
               end else begin
                  draw_pc(dst);
               end
               trace_valid_i  = 1'b1;
               trace_priv_i   = r.priv;
               trace_type_i   = r.ctype;
               trace_pc_src_i = src;
               trace_pc_dst_i = dst;
               model_trace(r.priv, r.ctype, src, dst, exp_hit);
               @(posedge clk_i);
               #1;
               trace_valid_i = 1'b0;
               // Pulse lives in the cycle after the sampling edge
               #4;
               check_value("trigger_o", EntryWidth'(exp_hit), EntryWidth'(trigger_o));
               @(posedge clk_i);
               #1;
               // No valid trace at this edge, so the pulse is over
               check_value("trigger_o", EntryWidth'(1'b0), EntryWidth'(trigger_o));
            end
         end
         K_RB: begin
            idx       = r.model ? m_last : r.arg[IdxW-1:0];
            rd_addr_i = idx;
            @(posedge clk_i);
            #1;
            check_value("rd_data_o", m_mem[idx], rd_data_o);
            @(posedge clk_i);
            #1;
         end
         default: begin
            cfg_addr_i = r.arg[2:0];
            exp_word   = r.model ? model_status() : r.data;
            #4;
            check_value("cfg_rdata_o", EntryWidth'(exp_word), EntryWidth'(cfg_rdata_o));
            @(posedge clk_i);
            #1;
         end
      endcase
   endtask

   // Four cycles per table row plus margin
   initial begin
      int unsigned limit;
      limit = NumRows * 4 + 20;
      repeat (limit) @(posedge clk_i);
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      stop_run();
   end

   initial begin
      rst_n_i        = 1'b0;
      trace_valid_i  = 1'b0;
      trace_priv_i   = 2'd0;
      trace_type_i   = 3'd0;
      trace_pc_src_i = 32'd0;
      trace_pc_dst_i = 32'd0;
      cfg_we_i       = 1'b0;
      cfg_addr_i     = 3'd0;
      cfg_wdata_i    = 32'd0;
      rd_addr_i      = '0;
      m_ctrl         = 32'd0;
      m_lo           = 32'd0;
      m_hi           = 32'd0;
      m_trig         = 32'd0;
      m_wr           = '0;
      m_last         = '0;
      m_first        = '0;
      m_count        = 0;
      m_frozen       = 1'b0;
      lfsr_q         = 32'h3576ff7d;
      repeat (4) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      check_value("trigger_o", EntryWidth'(1'b0), EntryWidth'(trigger_o));
      for (int i = 0; i < NumRows; i++) begin
         apply_row(Rows[i]);
         check_value("core_select_o", EntryWidth'(m_ctrl[2]), EntryWidth'(core_select_o));
      end
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
hw/snooper_pkg.sv
hw/snoop_cfg_if.sv
hw/snoop_cfg_regs.sv
hw/trace_filter.sv
hw/trace_trigger.sv
hw/trace_recorder.sv
hw/snooper_top.sv
testbench/tb_snooper.sv

/* run_sim.sh */
#!/bin/sh
# Build the snooper testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f sources.f --top-module tb_snooper \
   -o tb_snooper > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_snooper > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
